//--- flist.f
+incdir+hdl
hdl/sdmac_pkg.sv
hdl/addr_decoder.sv
hdl/registers_cntr.sv
hdl/registers_istr.sv
hdl/registers_term.sv
hdl/registers.sv
tests/tb_clkgen.sv
tests/registers_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the register block testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

TOP=registers_tb
OBJ_DIR=obj_dir
LOG=sim.log

rm -rf "$OBJ_DIR" "$LOG"

verilator --binary --top-module "$TOP" -f flist.f -Mdir "$OBJ_DIR" -o "$TOP"

"./$OBJ_DIR/$TOP" | tee "$LOG"

if grep -q "^TEST OK$" "$LOG"; then
  echo "Simulation passed"
else
  echo "Simulation failed, see $LOG"
  exit 1
fi

//--- tests/registers_tb.sv
// Directed tests, CPU bus access tasks, watchdog and summary for the SDMAC register block
`timescale 1ns/100ps
`include "sdmac_consts.svh"

module registers_tb;

  localparam int CLK_NS      = 4;
  localparam int ACK_LIMIT   = 8;   // Cycles to wait for DSACK
  localparam int WD_WINDOW   = 6;   // Cycles a WD access is held
  localparam int BUDGET      = 10 + 60 + 140 + 60 + 180 + 80 + 140;  // Reset, then per test
  localparam int WATCHDOG_NS = 2 * BUDGET * CLK_NS;

  logic        ACR_WR;
  logic        RST_;
  logic [7:0]  addr;
  logic        dmac_;
  logic        as_;
  logic        rw;
  logic [31:0] mid;
  logic        stopflush;
  logic        fifoempty;
  logic        fifofull;
  logic        inta_i;
  logic [31:0] mod;
  logic        preset;
  logic        flushfifo;
  logic        acr_load;
  logic        a1;
  logic        int_o_;
  logic        dmadir;
  logic        dmaena;
  logic        reg_dsk_;
  logic        wd_reg_req;

  int   err_cnt;
  int   tests_passed;
  int   tests_failed;
  int   ack_edges;     // Edges from access start to DSACK
  int   acr_load_cnt;  // Cycles acr_load was seen high
  logic exp_dmaena;    // Model of the DMA enable

  tb_clkgen u_clkgen (.ACR_WR(ACR_WR), .RST_(RST_));

  registers UUT (.*);

  task automatic report_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    $display("MISMATCH %s: expected 0x%h, actual 0x%h at %0t ns", name, exp, act, $time);
    err_cnt++;
  endtask

  task automatic report_bit(input string name, input logic exp, input logic act);
    $display("MISMATCH %s: expected 0x%h, actual 0x%h at %0t ns", name, exp, act, $time);
    err_cnt++;
  endtask

  // Expected ISTR, FIFO flags taken from the driven inputs
  function automatic logic [31:0] status_word(input logic int_f, input logic ints);
    return {23'd0, int_f, ints, 5'd0, fifofull, fifoempty};
  endfunction

  // One access, starts and ends just after a falling edge
  task automatic bus_cycle(input logic [7:0] ofs, input logic rd, input logic [31:0] wdata,
                           output logic [31:0] rdata);
    int   n;
    logic ack_seen;
    n            = 0;
    ack_seen     = 1'b0;
    rdata        = 32'h0;
    acr_load_cnt = 0;
    addr  = ofs;
    rw    = rd;
    mid   = wdata;
    dmac_ = 1'b0;
    as_   = 1'b0;
    while (!ack_seen && n < ACK_LIMIT) begin
      @(negedge ACR_WR);
      n++;
      if (acr_load) acr_load_cnt++;
      if (!reg_dsk_) begin
        ack_seen = 1'b1;
        rdata    = mod;  // Stable half a cycle before release
      end
    end
    ack_edges = n - 1;   // First sample follows edge k
    if (!ack_seen) begin
      $display("ERROR: no acknowledge for offset 0x%h within %0d cycles", ofs, ACK_LIMIT);
      err_cnt++;
    end
    as_   = 1'b1;
    dmac_ = 1'b1;
    rw    = 1'b1;
    mid   = 32'h0;
    @(negedge ACR_WR);   // Edge that sees as_ high
  endtask

  task automatic bus_write(input logic [7:0] ofs, input logic [31:0] data);
    logic [31:0] unused_rd;
    bus_cycle(ofs, 1'b0, data, unused_rd);
  endtask

  task automatic bus_read(input logic [7:0] ofs, output logic [31:0] data);
    bus_cycle(ofs, 1'b1, 32'h0, data);
  endtask

  // WD window access, held for a fixed time since no DSACK comes
  task automatic wd_access(input logic [7:0] ofs, input logic rd);
    int n;
    addr  = ofs;
    rw    = rd;
    dmac_ = 1'b0;
    as_   = 1'b0;
    for (n = 0; n < WD_WINDOW; n++) begin
      @(negedge ACR_WR);
      if (reg_dsk_ !== 1'b1) report_bit("reg_dsk_", 1'b1, reg_dsk_);
      if (wd_reg_req !== 1'b1) report_bit("wd_reg_req", 1'b1, wd_reg_req);
    end
    as_   = 1'b1;
    dmac_ = 1'b1;
    rw    = 1'b1;
    @(negedge ACR_WR);
    if (wd_reg_req !== 1'b0) report_bit("wd_reg_req", 1'b0, wd_reg_req);
  endtask

  task automatic close_test(input string name, input int errs_before);
    if (err_cnt == errs_before) begin
      tests_passed++;
      $display("%-14s passed", name);
    end else begin
      tests_failed++;
      $display("%-14s failed with %0d errors", name, err_cnt - errs_before);
    end
  endtask

  task automatic reset_and_status();
    int          e0;
    logic [31:0] rd;
    logic [31:0] rnd;
    e0 = err_cnt;
    if (reg_dsk_ !== 1'b1) report_bit("reg_dsk_", 1'b1, reg_dsk_);
    if (int_o_ !== 1'b1) report_bit("int_o_", 1'b1, int_o_);
    if (flushfifo !== 1'b0) report_bit("flushfifo", 1'b0, flushfifo);
    if (preset !== 1'b0) report_bit("preset", 1'b0, preset);
    if (dmaena !== 1'b0) report_bit("dmaena", 1'b0, dmaena);
    if (dmadir !== 1'b0) report_bit("dmadir", 1'b0, dmadir);
    if (a1 !== 1'b0) report_bit("a1", 1'b0, a1);
    if (wd_reg_req !== 1'b0) report_bit("wd_reg_req", 1'b0, wd_reg_req);
    if (acr_load !== 1'b0) report_bit("acr_load", 1'b0, acr_load);
    if (mod !== 32'h0) report_word("mod", 32'h0, mod);  // Idle bus
    bus_read(`SDMAC_OFS_CNTR, rd);
    if (rd !== 32'h0) report_word("cntr", 32'h0, rd);
    repeat (4) begin
      rnd       = $urandom;
      fifoempty = rnd[0];
      fifofull  = rnd[1];
      bus_read(`SDMAC_OFS_ISTR, rd);
      if (rd !== status_word(1'b0, 1'b0)) report_word("istr", status_word(1'b0, 1'b0), rd);
    end
    close_test("reset_status", e0);
  endtask

  task automatic control_register();
    int          e0;
    logic [31:0] wdata;
    logic [31:0] rd;
    logic [31:0] exp;
    e0 = err_cnt;
    repeat (6) begin
      wdata = $urandom;
      bus_write(`SDMAC_OFS_CNTR, wdata);
      bus_read(`SDMAC_OFS_CNTR, rd);
      exp = {23'd0, exp_dmaena, wdata[7:0]};  // Bit 8 shows DMA state
      if (rd !== exp) report_word("cntr", exp, rd);
      if (preset !== wdata[4]) report_bit("preset", wdata[4], preset);
      if (dmadir !== wdata[1]) report_bit("dmadir", wdata[1], dmadir);
    end
    bus_write(`SDMAC_OFS_CNTR, 32'h0);
    close_test("control_reg", e0);
  endtask

  task automatic dma_enable();
    int          e0;
    int          i;
    logic [7:0]  ofs;
    logic [31:0] rd;
    e0 = err_cnt;
    for (i = 0; i < 4; i++) begin
      ofs = i[0] ? `SDMAC_OFS_SP_DMA : `SDMAC_OFS_ST_DMA;
      if (i[1]) begin
        bus_read(ofs, rd);            // Actions also fire on reads
      end else begin
        bus_write(ofs, 32'h0);
      end
      exp_dmaena = ~i[0];
      if (dmaena !== exp_dmaena) report_bit("dmaena", exp_dmaena, dmaena);
      bus_read(`SDMAC_OFS_CNTR, rd);
      if (rd[8] !== exp_dmaena) report_bit("cntr[8]", exp_dmaena, rd[8]);
    end
    close_test("dma_enable", e0);
  endtask

  task automatic interrupt_flow();
    int          e0;
    logic [31:0] rd;
    e0 = err_cnt;
    bus_write(`SDMAC_OFS_CNTR, 32'h4);  // inten
    inta_i = 1'b1;
    repeat (2) @(negedge ACR_WR);       // Latch, then output stage
    if (int_o_ !== 1'b0) report_bit("int_o_", 1'b0, int_o_);
    bus_read(`SDMAC_OFS_ISTR, rd);
    if (rd !== status_word(1'b1, 1'b1)) report_word("istr", status_word(1'b1, 1'b1), rd);
    // Output held low all through the clear access
    fork
      bus_write(`SDMAC_OFS_CLR_INT, 32'h0);  // Source still active
      repeat (4) begin
        @(negedge ACR_WR);
        if (int_o_ !== 1'b0) report_bit("int_o_", 1'b0, int_o_);
      end
    join
    bus_read(`SDMAC_OFS_ISTR, rd);
    if (rd !== status_word(1'b1, 1'b1)) report_word("istr", status_word(1'b1, 1'b1), rd);
    if (int_o_ !== 1'b0) report_bit("int_o_", 1'b0, int_o_);
    inta_i = 1'b0;
    bus_write(`SDMAC_OFS_CLR_INT, 32'h0);
    if (int_o_ !== 1'b1) report_bit("int_o_", 1'b1, int_o_);
    bus_read(`SDMAC_OFS_ISTR, rd);
    if (rd !== status_word(1'b0, 1'b0)) report_word("istr", status_word(1'b0, 1'b0), rd);
    // Masked interrupt
    bus_write(`SDMAC_OFS_CNTR, 32'h0);
    inta_i = 1'b1;
    @(negedge ACR_WR);
    inta_i = 1'b0;
    repeat (3) begin
      @(negedge ACR_WR);
      if (int_o_ !== 1'b1) report_bit("int_o_", 1'b1, int_o_);
    end
    bus_read(`SDMAC_OFS_ISTR, rd);
    if (rd !== status_word(1'b0, 1'b1)) report_word("istr", status_word(1'b0, 1'b1), rd);
    bus_write(`SDMAC_OFS_CLR_INT, 32'h0);
    close_test("interrupts", e0);
  endtask

  task automatic flush_and_a1();
    int          e0;
    int          i;
    logic [31:0] wdata;
    e0 = err_cnt;
    if (flushfifo !== 1'b0) report_bit("flushfifo", 1'b0, flushfifo);
    bus_write(`SDMAC_OFS_FLUSH, 32'h0);
    if (flushfifo !== 1'b1) report_bit("flushfifo", 1'b1, flushfifo);
    stopflush = 1'b1;   // FIFO side reports flush done
    @(negedge ACR_WR);
    stopflush = 1'b0;
    if (flushfifo !== 1'b0) report_bit("flushfifo", 1'b0, flushfifo);
    for (i = 0; i < 4; i++) begin
      wdata     = $urandom;
      wdata[25] = i[0];  // Both A1 values
      bus_write(`SDMAC_OFS_ACR, wdata);
      if (acr_load_cnt != 1) report_word("acr_load cycles", 32'd1, acr_load_cnt);
      if (a1 !== wdata[25]) report_bit("a1", wdata[25], a1);
    end
    close_test("flush_a1", e0);
  endtask

  task automatic acknowledge_timing();
    int          e0;
    int          i;
    logic [7:0]  quiet_ofs [4];
    logic [31:0] rd;
    e0        = err_cnt;
    quiet_ofs = '{`SDMAC_OFS_WTC, 8'h2C, 8'h80, 8'hFC};  // All read zero
    bus_write(`SDMAC_OFS_CNTR, 32'hFF);  // Nonzero CNTR behind the quiet reads
    for (i = 0; i < 4; i++) begin
      bus_read(quiet_ofs[i], rd);
      if (ack_edges != `SDMAC_DSK_DELAY) report_word("dsack edges", `SDMAC_DSK_DELAY, ack_edges);
      if (rd !== 32'h0) report_word("mod", 32'h0, rd);
      if (reg_dsk_ !== 1'b1) report_bit("reg_dsk_", 1'b1, reg_dsk_);  // Back high with as_
      if (mod !== 32'h0) report_word("mod", 32'h0, mod);
    end
    bus_write(`SDMAC_OFS_CNTR, 32'h0);
    if (ack_edges != `SDMAC_DSK_DELAY) report_word("dsack edges", `SDMAC_DSK_DELAY, ack_edges);
    wd_access(`SDMAC_WD_BASE, 1'b1);
    wd_access(8'h4C, 1'b0);
    close_test("acknowledge", e0);
  endtask

  initial begin
    void'($urandom(32'hd045));  // One seed for the run
    addr         = 8'h00;
    dmac_        = 1'b1;
    as_          = 1'b1;
    rw           = 1'b1;
    mid          = 32'h0;
    stopflush    = 1'b0;
    fifoempty    = 1'b1;
    fifofull     = 1'b0;
    inta_i       = 1'b0;
    err_cnt      = 0;
    tests_passed = 0;
    tests_failed = 0;
    exp_dmaena   = 1'b0;
    wait (RST_ === 1'b1);
    @(negedge ACR_WR);
    reset_and_status();
    control_register();
    dma_enable();
    interrupt_flow();
    flush_and_a1();
    acknowledge_timing();
    $display("Summary: %0d tests passed, %0d tests failed, %0d check errors",
             tests_passed, tests_failed, err_cnt);
    if (tests_failed == 0 && err_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Twice the summed test budgets
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, run stopped", WATCHDOG_NS);
    $display("TEST FAILED");
    $finish;
  end

endmodule

//--- tests/tb_clkgen.sv
// Testbench clock source with 4 ns period and active low reset held for 3 cycles
`timescale 1ns/100ps

module tb_clkgen #(
  parameter int HALF_NS    = 2,  // Half of the 4 ns period
  parameter int RST_CYCLES = 3
) (
  output logic ACR_WR,
  output logic RST_
);

  initial begin
    ACR_WR = 1'b0;
    forever #(HALF_NS) ACR_WR = ~ACR_WR;
  end

  // Released on a falling edge, away from the sampling edge
  initial begin
    RST_ = 1'b0;
    repeat (RST_CYCLES) @(posedge ACR_WR);
    @(negedge ACR_WR);
    RST_ = 1'b1;
  end

endmodule

//--- hdl/registers.sv
// SDMAC host register block with flush flag, A1 capture and read multiplexer
`timescale 1ns/100ps
`include "sdmac_consts.svh"

module registers (
  input  logic                    ACR_WR,
  input  logic                    RST_,
  input  logic [7:0]              addr,
  input  logic                    dmac_,      // Chip select
  input  logic                    as_,
  input  logic                    rw,
  input  logic [`SDMAC_BUS_W-1:0] mid,        // CPU write data
  input  logic                    stopflush,  // Flush done, from FIFO side
  input  logic                    fifoempty,
  input  logic                    fifofull,
  input  logic                    inta_i,
  output logic [`SDMAC_BUS_W-1:0] mod,        // CPU read data
  output logic                    preset,
  output logic                    flushfifo,
  output logic                    acr_load,   // ACR write strobe to byte pointer
  output logic                    a1,
  output logic                    int_o_,
  output logic                    dmadir,
  output logic                    dmaena,
  output logic                    reg_dsk_,
  output logic                    wd_reg_req  // WD33C93 pass-through
);

  import sdmac_pkg::*;

  localparam int unsigned PAD_W = `SDMAC_BUS_W - `SDMAC_REG_W;

  cpu_word_u  mid_u;
  cntr_bits_t cntr_q;
  istr_bits_t istr_q;

  logic cntr_wr, st_dma, sp_dma, clr_int, flush;
  logic cntr_rd, istr_rd;
  logic reg_acc, acc;
  logic inten;

  assign mid_u = mid;

  addr_decoder u_addr_decoder (
    .ACR_WR     (ACR_WR),
    .RST_       (RST_),
    .addr       (addr),
    .dmac_      (dmac_),
    .as_        (as_),
    .rw         (rw),
    .cntr_wr    (cntr_wr),
    .acr_load   (acr_load),
    .st_dma     (st_dma),
    .sp_dma     (sp_dma),
    .clr_int    (clr_int),
    .flush      (flush),
    .cntr_rd    (cntr_rd),
    .istr_rd    (istr_rd),
    .wtc_rd     (),
    .wd_reg_req (wd_reg_req),
    .reg_acc    (reg_acc),
    .acc        (acc)
  );

  registers_cntr u_registers_cntr (
    .ACR_WR  (ACR_WR),
    .RST_    (RST_),
    .cntr_wr (cntr_wr),
    .st_dma  (st_dma),
    .sp_dma  (sp_dma),
    .mid     (mid_u),
    .cntr_q  (cntr_q),
    .inten   (inten),
    .preset  (preset),
    .dmadir  (dmadir),
    .dmaena  (dmaena)
  );

  registers_istr u_registers_istr (
    .ACR_WR    (ACR_WR),
    .RST_      (RST_),
    .fifoempty (fifoempty),
    .fifofull  (fifofull),
    .inta_i    (inta_i),
    .clr_int   (clr_int),
    .inten     (inten),
    .istr_q    (istr_q),
    .int_o_    (int_o_)
  );

  registers_term u_registers_term (
    .ACR_WR   (ACR_WR),
    .RST_     (RST_),
    .acc      (acc),
    .reg_acc  (reg_acc),
    .reg_dsk_ (reg_dsk_)
  );

  // Flush request, stopflush has priority
  always_ff @(posedge ACR_WR or negedge RST_) begin
    if (!RST_) begin
      flushfifo <= 1'b0;
    end else if (stopflush) begin
      flushfifo <= 1'b0;
    end else if (flush) begin
      flushfifo <= 1'b1;
    end
  end

  // A1 from bit 25 of an ACR write
  always_ff @(posedge ACR_WR or negedge RST_) begin
    if (!RST_) begin
      a1 <= 1'b0;
    end else if (acr_load) begin
      a1 <= mid_u.acr.a1;
    end
  end

  // Read mux, zero when idle
  always_comb begin
    if (cntr_rd) begin
      mod = {{PAD_W{1'b0}}, cntr_q};
    end else if (istr_rd) begin
      mod = {{PAD_W{1'b0}}, istr_q};
    end else begin
      mod = '0;  // WTC, unmapped and idle
    end
  end

endmodule

//--- hdl/registers_term.sv
// DSACK generator counting the acknowledge delay for internal register accesses
`timescale 1ns/100ps
`include "sdmac_consts.svh"

module registers_term (
  input  logic ACR_WR,
  input  logic RST_,
  input  logic acc,       // Access in progress
  input  logic reg_acc,   // Internal register targeted
  output logic reg_dsk_   // DSACK, low active
);

  localparam int unsigned DLY   = `SDMAC_DSK_DELAY;
  localparam int unsigned CNT_W = $clog2(DLY + 1);

  logic [CNT_W-1:0] cnt;
  logic             run;   // Internal access underway

  assign run = acc & reg_acc;

  // Saturates at DLY, back to zero once acc drops
  always_ff @(posedge ACR_WR or negedge RST_) begin
    if (!RST_) begin
      cnt <= '0;
    end else if (!run) begin
      cnt <= '0;
    end else if (cnt != CNT_W'(DLY)) begin
      cnt <= cnt + 1'b1;
    end
  end

  // Low from edge k+DLY, high again on the edge that drops acc
  assign reg_dsk_ = ~(run & (cnt == CNT_W'(DLY)));

endmodule

//--- hdl/registers_istr.sv
// Interrupt latch, status word assembly and registered interrupt output
`timescale 1ns/100ps

module registers_istr (
  input  logic                   ACR_WR,
  input  logic                   RST_,
  input  logic                   fifoempty,
  input  logic                   fifofull,
  input  logic                   inta_i,    // SCSI chip interrupt, high active
  input  logic                   clr_int,   // Clear strobe from decoder
  input  logic                   inten,     // From control register
  output sdmac_pkg::istr_bits_t  istr_q,
  output logic                   int_o_     // INT2 to CPU, low active
);

  logic ints;   // Latched SCSI interrupt
  logic int_f;  // Interrupt at output

  // Source wins over clear, a pending request is never dropped
  always_ff @(posedge ACR_WR or negedge RST_) begin
    if (!RST_) begin
      ints <= 1'b0;
    end else if (inta_i) begin
      ints <= 1'b1;
    end else if (clr_int) begin
      ints <= 1'b0;
    end
  end

  // One cycle behind ints
  always_ff @(posedge ACR_WR or negedge RST_) begin
    if (!RST_) begin
      int_f  <= 1'b0;
      int_o_ <= 1'b1;
    end else begin
      int_f  <= ints & inten;
      int_o_ <= ~(ints & inten);
    end
  end

  // Status word, FIFO flags live
  always_comb begin
    istr_q            = '0;
    istr_q.int_f      = int_f;
    istr_q.ints       = ints;
    istr_q.fifo_full  = fifofull;
    istr_q.fifo_empty = fifoempty;
  end

endmodule

//--- hdl/registers_cntr.sv
// Control register with separate DMA enable set and clear strobes
`timescale 1ns/100ps

module registers_cntr (
  input  logic                   ACR_WR,
  input  logic                   RST_,
  input  logic                   cntr_wr,  // CNTR write strobe
  input  logic                   st_dma,   // Start DMA strobe
  input  logic                   sp_dma,   // Stop DMA strobe
  input  sdmac_pkg::cpu_word_u   mid,
  output sdmac_pkg::cntr_bits_t  cntr_q,   // Readback, dmaena in bit 8
  output logic                   inten,
  output logic                   preset,
  output logic                   dmadir,
  output logic                   dmaena
);

  import sdmac_pkg::*;

  cntr_bits_t cntr_r;
  logic       dmaena_r;   // Kept apart, not CPU writable

  // Writable fields only
  always_ff @(posedge ACR_WR or negedge RST_) begin
    if (!RST_) begin
      cntr_r <= '0;
    end else if (cntr_wr) begin
      cntr_r <= mid.ctl.cntr;
    end
  end

  // Stop beats start
  always_ff @(posedge ACR_WR or negedge RST_) begin
    if (!RST_) begin
      dmaena_r <= 1'b0;
    end else if (sp_dma) begin
      dmaena_r <= 1'b0;
    end else if (st_dma) begin
      dmaena_r <= 1'b1;
    end
  end

  // Readback with live DMA state in bit 8
  always_comb begin
    cntr_q        = cntr_r;
    cntr_q.dmaena = dmaena_r;
  end

  assign inten  = cntr_r.inten;
  assign preset = cntr_r.prest;  // Peripheral reset
  assign dmadir = cntr_r.ddir;
  assign dmaena = dmaena_r;

endmodule

//--- hdl/addr_decoder.sv
// Access start detection and register offset decoder with strobes and read selects
`timescale 1ns/100ps
`include "sdmac_consts.svh"

module addr_decoder (
  input  logic       ACR_WR,
  input  logic       RST_,
  input  logic [7:0] addr,
  input  logic       dmac_,      // Chip select, low active
  input  logic       as_,        // Address strobe, low active
  input  logic       rw,         // 1 for read
  output logic       cntr_wr,
  output logic       acr_load,
  output logic       st_dma,
  output logic       sp_dma,
  output logic       clr_int,
  output logic       flush,
  output logic       cntr_rd,
  output logic       istr_rd,
  output logic       wtc_rd,
  output logic       wd_reg_req,
  output logic       reg_acc,
  output logic       acc
);

  logic [7:0] ofs;      // Longword aligned offset
  logic       start;    // First edge of an access
  logic       hit_wtc;
  logic       hit_cntr;
  logic       hit_acr;
  logic       hit_st;
  logic       hit_flush;
  logic       hit_clr;
  logic       hit_istr;
  logic       hit_sp;
  logic       hit_wd;

  assign ofs   = {addr[7:2], 2'b00};
  assign start = ~acc & ~as_ & ~dmac_;  // Qualified strobe, edge detected on acc

  assign hit_wtc   = (ofs == `SDMAC_OFS_WTC);
  assign hit_cntr  = (ofs == `SDMAC_OFS_CNTR);
  assign hit_acr   = (ofs == `SDMAC_OFS_ACR);
  assign hit_st    = (ofs == `SDMAC_OFS_ST_DMA);
  assign hit_flush = (ofs == `SDMAC_OFS_FLUSH);
  assign hit_clr   = (ofs == `SDMAC_OFS_CLR_INT);
  assign hit_istr  = (ofs == `SDMAC_OFS_ISTR);
  assign hit_sp    = (ofs == `SDMAC_OFS_SP_DMA);
  // WD window 0x40..0x4F
  assign hit_wd    = (ofs >= `SDMAC_WD_BASE) &&
                     (ofs <  (`SDMAC_WD_BASE + `SDMAC_WD_SPAN));

  always_ff @(posedge ACR_WR or negedge RST_) begin
    if (!RST_) begin
      cntr_wr    <= 1'b0;
      acr_load   <= 1'b0;
      st_dma     <= 1'b0;
      sp_dma     <= 1'b0;
      clr_int    <= 1'b0;
      flush      <= 1'b0;
      cntr_rd    <= 1'b0;
      istr_rd    <= 1'b0;
      wtc_rd     <= 1'b0;
      wd_reg_req <= 1'b0;
      reg_acc    <= 1'b0;
      acc        <= 1'b0;
    end else begin
      // Single cycle strobes, high from edge k to k+1
      cntr_wr  <= start & ~rw & hit_cntr;
      acr_load <= start & ~rw & hit_acr;
      st_dma   <= start & hit_st;     // Actions fire in either direction
      sp_dma   <= start & hit_sp;
      clr_int  <= start & hit_clr;
      flush    <= start & hit_flush;

      // Held levels, dropped at the edge that sees as_ high
      if (as_) begin
        acc        <= 1'b0;
        cntr_rd    <= 1'b0;
        istr_rd    <= 1'b0;
        wtc_rd     <= 1'b0;
        wd_reg_req <= 1'b0;
        reg_acc    <= 1'b0;
      end else if (start) begin
        acc        <= 1'b1;
        cntr_rd    <= rw & hit_cntr;
        istr_rd    <= rw & hit_istr;
        wtc_rd     <= rw & hit_wtc;
        wd_reg_req <= hit_wd;
        reg_acc    <= ~hit_wd;        // Unmapped offsets still get DSACK
      end
    end
  end

endmodule

//--- hdl/sdmac_pkg.sv
// Control and status register layouts and the decoded CPU bus word
`include "sdmac_consts.svh"

package sdmac_pkg;

  // Control register, bit 8 read only
  typedef struct packed {
    logic       dmaena;   // DMA running, set by ST_DMA
    logic [2:0] spare_hi; // Stored as written
    logic       prest;    // Peripheral reset
    logic       spare_md;
    logic       inten;    // Interrupt enable
    logic       ddir;     // DMA direction
    logic       spare_lo;
  } cntr_bits_t;

  // Interrupt status register
  typedef struct packed {
    logic       int_f;      // Interrupt asserted at output
    logic       ints;       // Latched SCSI interrupt
    logic [4:0] rsvd;       // Read as zero
    logic       fifo_full;
    logic       fifo_empty;
  } istr_bits_t;

  // Control register write view
  typedef struct packed {
    logic [`SDMAC_BUS_W-`SDMAC_REG_W-1:0] pad;
    cntr_bits_t                           cntr;
  } cpu_cntr_view_t;

  // ACR write view, A1 sits in bit 25
  typedef struct packed {
    logic [5:0]  pad_hi;
    logic        a1;
    logic [24:0] pad_lo;
  } cpu_acr_view_t;

  // Same bus word, decoded per target register
  typedef union packed {
    cpu_cntr_view_t ctl;
    cpu_acr_view_t  acr;
  } cpu_word_u;

endpackage

//--- hdl/sdmac_consts.svh
// Bus and register widths, register offsets, WD window and acknowledge delay
`ifndef SDMAC_CONSTS_SVH
`define SDMAC_CONSTS_SVH

// CPU data bus
`define SDMAC_BUS_W 32
// Control and status register width
`define SDMAC_REG_W 9

// Byte offsets, decoded on addr[7:2]
`define SDMAC_OFS_WTC     8'h04  // Word transfer count, reads zero
`define SDMAC_OFS_CNTR    8'h08  // Control register
`define SDMAC_OFS_ACR     8'h0C  // Address counter, only A1 kept
`define SDMAC_OFS_ST_DMA  8'h10  // Start DMA action
`define SDMAC_OFS_FLUSH   8'h14  // Flush FIFO action
`define SDMAC_OFS_CLR_INT 8'h18  // Clear interrupt action
`define SDMAC_OFS_ISTR    8'h1C  // Interrupt status register
`define SDMAC_OFS_SP_DMA  8'h3C  // Stop DMA action

// WD33C93 pass-through window
`define SDMAC_WD_BASE 8'h40
`define SDMAC_WD_SPAN 8'h10  // 0x40 to 0x4F

// Cycles from access start to DSACK
`define SDMAC_DSK_DELAY 2

`endif
